// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = icache_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))
TRACE     = testbench/icache_trace.txt

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(TRACE)
	@out="$$(./$(SIM_BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: design/fill_bus_pkg.sv
package fill_bus_pkg;

    // ------------------------------------------------------------
    // line transfer between the cache and the backing memory
    // ------------------------------------------------------------
    localparam int LINE_W = 256;  // one whole 32-byte line per transfer

    // line number is the fetch address without its byte offset
    localparam int LINE_ADDR_W = 10;

    localparam int NUM_MEM_LINES = 2 ** LINE_ADDR_W;  // depth of the backing store

endpackage

// File: design/icache.sv
module icache (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               ren,
    input  logic [icache_geom_pkg::ADDR_W-1:0] addr,
    input  logic [fill_bus_pkg::LINE_W-1:0]    ic_fill_data,
    input  logic                               ic_miss_ack,
    input  logic                               v_init,
    output logic [fill_bus_pkg::LINE_W-1:0]    r_data,
    output logic                               r_ready,
    output logic                               ic_miss,
    output logic [icache_geom_pkg::ADDR_W-1:0] ic_addr
);

    icache_geom_pkg::fetch_addr_u       fa;         // incoming fetch address
    icache_geom_pkg::fetch_addr_u       miss_addr;  // line-aligned address for the fill
    logic [icache_geom_pkg::TAG_W-1:0]  tag_in_cache;
    logic                               tag_valid;
    logic                               hit;

    assign fa.flat = addr;  // fetch unit hands over the flat word

    // ------------------------------------------------------------
    // lookup
    // ------------------------------------------------------------
    assign hit     = tag_valid && (tag_in_cache == fa.fields.tag);
    assign r_ready = ren && hit;   // line is on r_data in the same cycle
    assign ic_miss = ren && !hit;  // held until the fill lands

    // Offset is cleared so the memory sees the start of the line.
    assign miss_addr.fields.tag    = fa.fields.tag;
    assign miss_addr.fields.index  = fa.fields.index;
    assign miss_addr.fields.offset = '0;
    assign ic_addr                 = miss_addr.flat;

    // ------------------------------------------------------------
    // stores, both written by the fill acknowledge
    // ------------------------------------------------------------
    icache_tag_store u_tag_store (
        .clk       (clk),
        .rst       (rst),
        .index     (fa.fields.index),
        .wr        (ic_miss_ack),
        .wr_tag    (fa.fields.tag),
        .v_init    (v_init),
        .tag       (tag_in_cache),
        .tag_valid (tag_valid)
    );

    icache_data_store u_data_store (
        .clk       (clk),
        .index     (fa.fields.index),
        .wr        (ic_miss_ack),
        .fill_data (ic_fill_data),
        .r_data    (r_data)
    );

    // a fill that v_init does not cancel turns the held fetch into a hit
    a_fill_hits: assert property (
        @(posedge clk) disable iff (rst)
        (ic_miss_ack && !v_init) |=> (!ren || r_ready)
    ) else $error("fetch did not hit in the cycle after its fill");

    // the line memory may only answer a request that is still open
    a_ack_needs_miss: assert property (
        @(posedge clk) disable iff (rst)
        ic_miss_ack |-> ic_miss
    ) else $error("ic_miss_ack without an open miss");

endmodule

// File: design/icache_data_store.sv
module icache_data_store (
    input  logic                                clk,
    input  logic [icache_geom_pkg::INDEX_W-1:0] index,
    input  logic                                wr,
    input  logic [fill_bus_pkg::LINE_W-1:0]     fill_data,
    output logic [fill_bus_pkg::LINE_W-1:0]     r_data
);

    // ------------------------------------------------------------
    // line array
    // ------------------------------------------------------------
    logic [fill_bus_pkg::LINE_W-1:0] lines [0:icache_geom_pkg::NUM_LINES-1];

    always_ff @(posedge clk) begin
        if (wr) begin
            lines[index] <= fill_data;  // whole line replaced on fill
        end
    end

    // contents only count once the matching valid bit is set
    assign r_data = lines[index];

endmodule

// File: design/icache_geom_pkg.sv
package icache_geom_pkg;

    // ------------------------------------------------------------
    // fetch address split
    // ------------------------------------------------------------
    localparam int TAG_W    = 6;  // physical tag above the index
    localparam int INDEX_W  = 4;  // selects one of the cache lines
    localparam int OFFSET_W = 5;  // byte offset in a 32-byte line
    localparam int ADDR_W   = TAG_W + INDEX_W + OFFSET_W;  // 15-bit fetch address

    localparam int NUM_LINES = 2 ** INDEX_W;  // entries in each store

    // field view of the fetch address, tag in the top bits
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } fetch_fields_t;

    // ------------------------------------------------------------
    // one address word read either flat or as its fields
    // ------------------------------------------------------------
    typedef union packed {
        logic [ADDR_W-1:0] flat;    // as driven by the fetch unit
        fetch_fields_t     fields;  // as used for the lookup
    } fetch_addr_u;

endpackage

// File: design/icache_tag_store.sv
module icache_tag_store (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [icache_geom_pkg::INDEX_W-1:0] index,
    input  logic                                wr,
    input  logic [icache_geom_pkg::TAG_W-1:0]   wr_tag,
    input  logic                                v_init,
    output logic [icache_geom_pkg::TAG_W-1:0]   tag,
    output logic                                tag_valid
);

    logic [icache_geom_pkg::TAG_W-1:0]     tags [0:icache_geom_pkg::NUM_LINES-1];
    logic [icache_geom_pkg::NUM_LINES-1:0] valid;  // one bit per entry

    // ------------------------------------------------------------
    // tag array, written on fill
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr) begin
            tags[index] <= wr_tag;  // tag of the line being filled
        end
    end

    // ------------------------------------------------------------
    // valid bits
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || v_init) begin
            valid <= '0;  // invalidate wins over a fill in the same cycle
        end else if (wr) begin
            valid[index] <= 1'b1;
        end
    end

    assign tag       = tags[index];   // asynchronous read
    assign tag_valid = valid[index];

    // once reset has run, a known index always gives a known valid bit
    a_valid_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(index) |-> !$isunknown(tag_valid)
    ) else $error("tag_valid is unknown for index %0d", index);

endmodule

// File: design/icache_top.sv
module icache_top #(
    parameter int FILL_LATENCY = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 ren,
    input  logic [icache_geom_pkg::ADDR_W-1:0]   addr,
    input  logic                                 v_init,
    input  logic                                 mem_wr,
    input  logic [fill_bus_pkg::LINE_ADDR_W-1:0] mem_wr_addr,
    input  logic [fill_bus_pkg::LINE_W-1:0]      mem_wr_data,
    output logic [fill_bus_pkg::LINE_W-1:0]      r_data,
    output logic                                 r_ready,
    output logic                                 ic_miss
);

    // ------------------------------------------------------------
    // fill path between cache and line memory
    // ------------------------------------------------------------
    logic [icache_geom_pkg::ADDR_W-1:0] ic_addr;       // flat line-aligned address
    logic [fill_bus_pkg::LINE_W-1:0]    ic_fill_data;
    logic                               ic_miss_ack;

    icache u_icache (
        .clk          (clk),
        .rst          (rst),
        .ren          (ren),
        .addr         (addr),
        .ic_fill_data (ic_fill_data),
        .ic_miss_ack  (ic_miss_ack),
        .v_init       (v_init),
        .r_data       (r_data),
        .r_ready      (r_ready),
        .ic_miss      (ic_miss),
        .ic_addr      (ic_addr)
    );

    line_memory #(
        .FILL_LATENCY (FILL_LATENCY)
    ) u_line_memory (
        .clk          (clk),
        .rst          (rst),
        .ic_miss      (ic_miss),
        .ic_addr      (ic_addr),
        .mem_wr       (mem_wr),
        .mem_wr_addr  (mem_wr_addr),
        .mem_wr_data  (mem_wr_data),
        .ic_fill_data (ic_fill_data),
        .ic_miss_ack  (ic_miss_ack)
    );

endmodule

// File: design/line_memory.sv
module line_memory #(
    parameter int FILL_LATENCY = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 ic_miss,
    input  logic [icache_geom_pkg::ADDR_W-1:0]   ic_addr,
    input  logic                                 mem_wr,
    input  logic [fill_bus_pkg::LINE_ADDR_W-1:0] mem_wr_addr,
    input  logic [fill_bus_pkg::LINE_W-1:0]      mem_wr_data,
    output logic [fill_bus_pkg::LINE_W-1:0]      ic_fill_data,
    output logic                                 ic_miss_ack
);

    localparam int CNT_W = $clog2(FILL_LATENCY + 1);  // counts 0 up to FILL_LATENCY

    logic [fill_bus_pkg::LINE_W-1:0]      mem [0:fill_bus_pkg::NUM_MEM_LINES-1];
    logic [fill_bus_pkg::LINE_ADDR_W-1:0] fill_line;
    logic [CNT_W-1:0]                     cnt;
    logic                                 cnt_done;

    // ------------------------------------------------------------
    // backing store with its preload port
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            mem[mem_wr_addr] <= mem_wr_data;  // cached copies are not touched
        end
    end

    assign fill_line    = ic_addr[icache_geom_pkg::ADDR_W-1:icache_geom_pkg::OFFSET_W];
    assign ic_fill_data = mem[fill_line];  // valid whenever the ack is high

    // ------------------------------------------------------------
    // fill latency
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst || !ic_miss || ic_miss_ack) begin
            cnt <= '0;  // a dropped request is forgotten
        end else if (!cnt_done) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign cnt_done = (cnt == CNT_W'(FILL_LATENCY));

    // Gated with ic_miss so that a request withdrawn in the last cycle
    // never sees an acknowledge.
    assign ic_miss_ack = ic_miss && cnt_done;

    a_ack_single: assert property (
        @(posedge clk) disable iff (rst)
        ic_miss_ack |=> !ic_miss_ack
    ) else $error("ic_miss_ack held for more than one cycle");

endmodule

// File: testbench/icache_tb.sv
module icache_tb;

    localparam int FILL_LATENCY  = 4;
    localparam int READY_TIMEOUT = 20;  // cycles allowed for r_ready
    localparam int LW            = fill_bus_pkg::LINE_W;

    logic                                 clk;
    logic                                 rst;
    logic                                 ren;
    logic [icache_geom_pkg::ADDR_W-1:0]   addr;
    logic                                 v_init;
    logic                                 mem_wr;
    logic [fill_bus_pkg::LINE_ADDR_W-1:0] mem_wr_addr;
    logic [LW-1:0]                        mem_wr_data;
    logic [LW-1:0]                        r_data;
    logic                                 r_ready;
    logic                                 ic_miss;

    int fetches_done;  // fetch records run to completion

    icache_top #(
        .FILL_LATENCY (FILL_LATENCY)
    ) UUT (
        .clk         (clk),
        .rst         (rst),
        .ren         (ren),
        .addr        (addr),
        .v_init      (v_init),
        .mem_wr      (mem_wr),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .r_data      (r_data),
        .r_ready     (r_ready),
        .ic_miss     (ic_miss)
    );

    always #2 clk = ~clk;  // period of 4

    // ------------------------------------------------------------
    // checking and failure
    // ------------------------------------------------------------
    task automatic check_value(input string name, input logic [LW-1:0] actual,
                               input logic [LW-1:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s is %h, expected %h",
                     $time, name, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic write_line(input logic [fill_bus_pkg::LINE_ADDR_W-1:0] line,
                              input logic [LW-1:0] data);
        @(posedge clk);
        mem_wr      <= 1'b1;
        mem_wr_addr <= line;
        mem_wr_data <= data;
        @(posedge clk);
        mem_wr      <= 1'b0;  // written at this edge
    endtask

    task automatic invalidate_all();
        @(posedge clk);
        v_init <= 1'b1;
        @(posedge clk);
        v_init <= 1'b0;
    endtask

    task automatic fetch_line(input logic [icache_geom_pkg::ADDR_W-1:0] a,
                              input int exp_hit, input logic [LW-1:0] exp_line);
        int cycles;
        @(posedge clk);
        ren  <= 1'b1;
        addr <= a;
        @(negedge clk);  // outputs settled in the ren cycle
        if (exp_hit != 0) begin
            check_value("r_ready", LW'(r_ready), LW'(1));
            check_value("ic_miss", LW'(ic_miss), LW'(0));
        end else begin
            check_value("ic_miss", LW'(ic_miss), LW'(1));
            check_value("r_ready", LW'(r_ready), LW'(0));
            cycles = 0;
            while (r_ready !== 1'b1) begin
                @(negedge clk);
                cycles++;
                if (cycles > READY_TIMEOUT) begin
                    stop_run($sformatf("timeout: r_ready never rose for address %h", a));
                end
                if (r_ready !== 1'b1) begin
                    check_value("ic_miss", LW'(ic_miss), LW'(1));  // held through the fill
                end
            end
            check_value("miss latency", LW'(cycles), LW'(FILL_LATENCY + 1));
        end
        check_value("r_data", r_data, exp_line);
        fetches_done++;
        @(posedge clk);
        ren <= 1'b0;
    endtask

    // ------------------------------------------------------------
    // trace replay
    // ------------------------------------------------------------
    initial begin
        int                                   fd;
        int                                   code;
        int                                   ch;
        int                                   exp_hit;
        logic [63:0]                          kind;
        logic [icache_geom_pkg::ADDR_W-1:0]   t_addr;
        logic [fill_bus_pkg::LINE_ADDR_W-1:0] t_line;
        logic [LW-1:0]                        t_data;

        clk          = 1'b0;
        rst          = 1'b1;
        ren          = 1'b0;
        addr         = '0;
        v_init       = 1'b0;
        mem_wr       = 1'b0;
        mem_wr_addr  = '0;
        mem_wr_data  = '0;
        fetches_done = 0;

        fd = $fopen("testbench/icache_trace.txt", "r");
        if (fd == 0) begin
            stop_run("could not open testbench/icache_trace.txt");
        end

        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("r_ready", LW'(r_ready), LW'(0));  // idle after reset
        check_value("ic_miss", LW'(ic_miss), LW'(0));

        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                break;
            end
            if (kind == "#") begin
                ch = $fgetc(fd);  // skip the rest of a comment line
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (kind == "P" || kind == "W") begin
                code = $fscanf(fd, "%h %h", t_line, t_data);
                if (code != 2) begin
                    stop_run("malformed write record in the trace");
                end
                write_line(t_line, t_data);  // cached copies stay as they are
            end else if (kind == "F") begin
                code = $fscanf(fd, "%h %d %h", t_addr, exp_hit, t_data);
                if (code != 3) begin
                    stop_run("malformed fetch record in the trace");
                end
                fetch_line(t_addr, exp_hit, t_data);
            end else if (kind == "I") begin
                invalidate_all();
            end else begin
                stop_run($sformatf("unknown record kind %0s in the trace", kind));
            end
        end
        $fclose(fd);

        if (fetches_done > 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("STATUS: FAIL");
            $fatal(1, "the trace held no fetch records");
        end
    end

endmodule

// File: testbench/icache_trace.txt
# records: P line data | W line data | F addr hit data | I
# line and addr in hex, hit is 1 for a hit and 0 for a miss, data is the 256-bit line in hex
P 023 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
P 043 fedcba9876543210fedcba9876543210fedcba9876543210fedcba9876543210
P 005 5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa
P 3ff 00000000ffffffff00000000ffffffff00000000ffffffff00000000ffffffff
# cold miss, then hits at other offsets of the same line
F 0460 0 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
F 047c 1 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
F 0461 1 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
# same index with another tag replaces the line
F 0864 0 fedcba9876543210fedcba9876543210fedcba9876543210fedcba9876543210
F 0460 0 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
F 0468 1 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
F 00a0 0 5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa
F 00bf 1 5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa
# invalidate drops every line
I
F 00a4 0 5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa
F 0460 0 0123456789abcdef0123456789abcdef0123456789abcdef0123456789abcdef
# memory write leaves the cached copy stale until the next invalidate
W 005 0f1e2d3c4b5a69780f1e2d3c4b5a69780f1e2d3c4b5a69780f1e2d3c4b5a6978
F 00a8 1 5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa5555aaaa
I
F 00a0 0 0f1e2d3c4b5a69780f1e2d3c4b5a69780f1e2d3c4b5a69780f1e2d3c4b5a6978
F 00b0 1 0f1e2d3c4b5a69780f1e2d3c4b5a69780f1e2d3c4b5a69780f1e2d3c4b5a6978
# top line of the address space
F 7fff 0 00000000ffffffff00000000ffffffff00000000ffffffff00000000ffffffff
F 7fe0 1 00000000ffffffff00000000ffffffff00000000ffffffff00000000ffffffff

// File: verilog.f
design/icache_geom_pkg.sv
design/fill_bus_pkg.sv
design/icache_tag_store.sv
design/icache_data_store.sv
design/icache.sv
design/line_memory.sv
design/icache_top.sv
testbench/icache_tb.sv
